// ==== rtl/neogeo_loader_pkg.sv ====
package neogeo_loader_pkg;

	// Host and SDRAM widths
	localparam int IOCTL_AW  = 27;
	localparam int PORT1_AW  = 24;
	localparam int PORT2_AW  = 26;
	localparam int SAMPLE_AW = 24;
	localparam int SIZE_W    = 32;

	// Cartridge file header layout
	localparam int HEADER_BYTES     = 4096;
	localparam int SIZE_FIELD_FIRST = 4;
	localparam int SIZE_FIELD_END   = 28;

	// Bank 3 prefixes
	localparam logic [4:0] BASE_SROM   = 5'b1111_1;
	localparam logic [7:0] BASE_LO_ROM = 8'b1101_1110;
	localparam logic [6:0] BASE_SFIX   = 7'b1110_100;
	localparam logic [5:0] BASE_SM1    = 6'b1110_11;
	localparam logic [4:0] BASE_FIX    = 5'b1110_0;
	localparam logic [4:0] BASE_MROM   = 5'b1111_0;

	// System file windows, host address bits 23:17
	localparam logic [6:0] WIN_LO_ROM = 7'b0000100;
	localparam logic [6:0] WIN_SFIX   = 7'b0000101;

	// Cartridge regions in file order
	typedef enum logic [2:0] {
		REG_P  = 3'd0,
		REG_S  = 3'd1,
		REG_M  = 3'd2,
		REG_V1 = 3'd3,
		REG_V2 = 3'd4,
		REG_C  = 3'd5
	} region_t;

	typedef enum logic [1:0] {
		LOAD_IDLE     = 2'd0,
		LOAD_WAIT_ACK = 2'd1,
		LOAD_NEXT     = 2'd2
	} load_state_t;

endpackage

// ==== rtl/cart_load_ctrl.sv ====
module cart_load_ctrl import neogeo_loader_pkg::*; (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic                ioctl_wr,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [PORT2_AW-1:0] region_size,
	input  logic                port1_ack,
	input  logic                port2_ack,
	output logic                system_wr,
	output logic                cart_wr,
	output logic                header_wr,
	output region_t             region,
	output logic [PORT2_AW-1:0] offset,
	output logic                port1_req,
	output logic                port2_req
);

	load_state_t state;
	logic        in_header;
	logic        header_last;
	logic        data_wr;
	logic        on_port1;
	logic        port_idle;

	// Index 0 and 1 are system files, index 2 is a cartridge
	assign system_wr = ioctl_download && (ioctl_index == 8'd0 || ioctl_index == 8'd1);
	assign cart_wr   = ioctl_download && ioctl_index == 8'd2;

	assign in_header   = ioctl_addr < HEADER_BYTES;
	assign header_last = ioctl_addr == IOCTL_AW'(HEADER_BYTES - 1);
	assign header_wr   = ioctl_wr && cart_wr && in_header;
	assign data_wr     = ioctl_wr && cart_wr && !in_header;

	// P, S and M live in bank 3
	assign on_port1  = region inside {REG_P, REG_S, REG_M};
	assign port_idle = on_port1 ? (port1_req == port1_ack) : (port2_req == port2_ack);

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			state     <= LOAD_IDLE;
			region    <= REG_P;
			offset    <= '0;
			port1_req <= 1'b0;
			port2_req <= 1'b0;
		end else begin
			if (ioctl_wr && system_wr) begin
				port1_req <= ~port1_req;
			end

			if (header_wr) begin
				region <= REG_P;
				offset <= '0;
				// Last header byte goes through the region check too
				state  <= header_last ? LOAD_NEXT : LOAD_IDLE;
			end else begin
				case (state)
					LOAD_IDLE: begin
						if (data_wr) begin
							if (on_port1) begin
								port1_req <= ~port1_req;
							end else begin
								port2_req <= ~port2_req;
							end
							state <= LOAD_WAIT_ACK;
						end
					end
					LOAD_WAIT_ACK: begin
						if (port_idle) begin
							offset <= offset + 1'b1;
							state  <= LOAD_NEXT;
						end
					end
					LOAD_NEXT: begin
						// Step past full or empty regions one per cycle
						if (offset == region_size) begin
							offset <= '0;
							if (region == REG_C) begin
								state <= LOAD_IDLE;
							end else begin
								region <= region_t'(region + 3'd1);
							end
						end else begin
							state <= LOAD_IDLE;
						end
					end
					default: state <= LOAD_IDLE;
				endcase
			end
		end
	end

	// Host must wait for the ack before the next byte
	a_no_strobe_pending: assert property (@(posedge CLK_48M) disable iff (!rst_n)
		ioctl_wr |-> (port1_req == port1_ack && port2_req == port2_ack))
		else $error("ioctl strobe while a port request is pending");

	a_region_in_range: assert property (@(posedge CLK_48M) disable iff (!rst_n)
		region inside {REG_P, REG_S, REG_M, REG_V1, REG_V2, REG_C})
		else $error("region stepped past REG_C");

endmodule

// ==== rtl/cart_header_regs.sv ====
module cart_header_regs import neogeo_loader_pkg::*; (
	input  logic                 CLK_48M,
	input  logic                 rst_n,
	input  logic                 header_wr,
	input  logic [IOCTL_AW-1:0]  ioctl_addr,
	input  logic [7:0]           ioctl_dout,
	input  region_t              region,
	output logic [SIZE_W-1:0]    p_size,
	output logic [SIZE_W-1:0]    s_size,
	output logic [SIZE_W-1:0]    m_size,
	output logic [SIZE_W-1:0]    v1_size,
	output logic [SIZE_W-1:0]    v2_size,
	output logic [SIZE_W-1:0]    c_size,
	output logic [PORT2_AW-1:0]  region_size,
	output logic [SAMPLE_AW-1:0] v1_mask,
	output logic [SAMPLE_AW-1:0] v2_mask,
	output logic [PORT2_AW-1:0]  c_mask,
	output logic                 pcm_merged,
	output logic [PORT2_AW-1:0]  samplea_base,
	output logic [PORT2_AW-1:0]  sampleb_base
);

	logic              size_byte;
	logic              last_byte;
	logic [SIZE_W-1:0] v1_mask_full;
	logic [SIZE_W-1:0] v2_mask_full;
	logic [SIZE_W-1:0] c_mask_full;

	// Next power of two at or above size, minus one
	function automatic logic [SIZE_W-1:0] size_mask(input logic [SIZE_W-1:0] size);
		logic [SIZE_W-1:0] m;
		m = size - 1'b1;
		for (int i = 1; i < SIZE_W; i = i * 2) begin
			m = m | (m >> i);
		end
		return (size == '0) ? '0 : m;
	endfunction

	assign size_byte = header_wr && ioctl_addr >= SIZE_FIELD_FIRST
		&& ioctl_addr < SIZE_FIELD_END;
	assign last_byte = header_wr && ioctl_addr == IOCTL_AW'(HEADER_BYTES - 1);

	assign v1_mask_full = size_mask(v1_size);
	assign v2_mask_full = size_mask(v2_size);
	assign c_mask_full  = size_mask(c_size);

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			{c_size, v2_size, v1_size, m_size, s_size, p_size} <= '0;
			v1_mask    <= '0;
			v2_mask    <= '0;
			c_mask     <= '0;
			pcm_merged <= 1'b0;
		end else begin
			// Little endian words, P first
			if (size_byte) begin
				{c_size, v2_size, v1_size, m_size, s_size, p_size} <=
					{ioctl_dout, c_size, v2_size, v1_size, m_size, s_size, p_size[SIZE_W-1:8]};
			end
			if (last_byte) begin
				v1_mask    <= v1_mask_full[SAMPLE_AW-1:0];
				v2_mask    <= v2_mask_full[SAMPLE_AW-1:0];
				c_mask     <= c_mask_full[PORT2_AW-1:0];
				// Some builders put ADPCM-B inside V1
				pcm_merged <= v2_size == '0;
			end
		end
	end

	always_comb begin
		case (region)
			REG_P:   region_size = p_size[PORT2_AW-1:0];
			REG_S:   region_size = s_size[PORT2_AW-1:0];
			REG_M:   region_size = m_size[PORT2_AW-1:0];
			REG_V1:  region_size = v1_size[PORT2_AW-1:0];
			REG_V2:  region_size = v2_size[PORT2_AW-1:0];
			REG_C:   region_size = c_size[PORT2_AW-1:0];
			default: region_size = '0;
		endcase
	end

	// Sample banks sit right after the sprites
	assign samplea_base = c_size[PORT2_AW-1:0];
	assign sampleb_base = pcm_merged ? c_size[PORT2_AW-1:0]
		: c_size[PORT2_AW-1:0] + v1_size[PORT2_AW-1:0];

endmodule

// ==== rtl/rom_addr_map.sv ====
module rom_addr_map import neogeo_loader_pkg::*; (
	input  logic                system_wr,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  region_t             region,
	input  logic [PORT2_AW-1:0] offset,
	input  logic [SIZE_W-1:0]   c_size,
	input  logic [SIZE_W-1:0]   v1_size,
	output logic [PORT1_AW-1:0] port1_addr,
	output logic [1:0]          port1_ds,
	output logic [PORT2_AW-1:0] port2_addr,
	output logic [1:0]          port2_ds,
	output logic [15:0]         port1_d,
	output logic [15:0]         port2_d
);

	logic [PORT1_AW-1:0] system_addr;
	logic [PORT1_AW-1:0] cart_addr;
	logic [PORT2_AW-1:0] v1_base;
	logic [PORT2_AW-1:0] v2_base;

	// Bank 3 map for BIOS, LO ROM, SFIX and SM1
	always_comb begin
		if (ioctl_addr[23:19] == 5'd0) begin
			system_addr = {BASE_SROM, ioctl_addr[18:0]};
		end else if (ioctl_addr[23:17] == WIN_LO_ROM) begin
			system_addr = {BASE_LO_ROM, ioctl_addr[15:0]};
		end else if (ioctl_addr[23:17] == WIN_SFIX) begin
			// Fix tiles are stored column swizzled
			system_addr = {BASE_SFIX, ioctl_addr[16:5], ioctl_addr[2:0],
				~ioctl_addr[4], ioctl_addr[3]};
		end else begin
			system_addr = {BASE_SM1, ioctl_addr[17:0]};
		end
	end

	always_comb begin
		case (region)
			REG_S:   cart_addr = {BASE_FIX, offset[18:5], offset[2:0], ~offset[4], offset[3]};
			REG_M:   cart_addr = {BASE_MROM, offset[18:0]};
			default: cart_addr = offset[PORT1_AW-1:0];
		endcase
	end

	assign port1_addr = system_wr ? system_addr : cart_addr;

	// Banks 0-2 hold C, then V1, then V2
	assign v1_base = c_size[PORT2_AW-1:0];
	assign v2_base = c_size[PORT2_AW-1:0] + v1_size[PORT2_AW-1:0];

	always_comb begin
		case (region)
			REG_V1:  port2_addr = v1_base + offset;
			REG_V2:  port2_addr = v2_base + offset;
			// Sprite planes interleaved into 32 bit words
			default: port2_addr = {offset[25:7], ioctl_addr[5:2], ~ioctl_addr[6],
				ioctl_addr[0], ioctl_addr[1]};
		endcase
	end

	assign port1_ds = {port1_addr[0], ~port1_addr[0]};
	assign port2_ds = {port2_addr[0], ~port2_addr[0]};
	assign port1_d  = {ioctl_dout, ioctl_dout};
	assign port2_d  = {ioctl_dout, ioctl_dout};

endmodule

// ==== rtl/adpcm_fetch.sv ====
module adpcm_fetch import neogeo_loader_pkg::*; (
	input  logic                 CLK_48M,
	input  logic                 rst_n,
	input  logic                 rd,
	input  logic [SAMPLE_AW-1:0] addr,
	input  logic [SAMPLE_AW-1:0] mask,
	input  logic [PORT2_AW-1:0]  base,
	output logic                 sample_req,
	input  logic                 sample_ack,
	input  logic [31:0]          sample_q,
	output logic [PORT2_AW-1:0]  sample_addr,
	output logic [7:0]           data,
	output logic                 data_ready
);

	logic                 rd_d;
	logic                 rd_rise;
	logic                 word_valid;
	logic [SAMPLE_AW-1:0] masked_addr;
	logic [SAMPLE_AW-1:0] addr_latch;
	logic                 new_word;

	assign rd_rise     = rd && !rd_d;
	assign masked_addr = addr & mask;

	// Only a different 32 bit word needs the SDRAM
	assign new_word = !word_valid || masked_addr[SAMPLE_AW-1:2] != addr_latch[SAMPLE_AW-1:2];

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			rd_d       <= 1'b0;
			word_valid <= 1'b0;
			addr_latch <= '0;
			sample_req <= 1'b0;
		end else begin
			rd_d <= rd;
			if (rd_rise) begin
				addr_latch <= masked_addr;
				word_valid <= 1'b1;
				if (new_word) begin
					sample_req <= ~sample_req;
				end
			end
		end
	end

	assign sample_addr = base + {{(PORT2_AW - SAMPLE_AW){1'b0}}, addr_latch};
	assign data_ready  = sample_req == sample_ack;

	always_comb begin
		case (addr_latch[1:0])
			2'd0: data = sample_q[7:0];
			2'd1: data = sample_q[15:8];
			2'd2: data = sample_q[23:16];
			default: data = sample_q[31:24];
		endcase
	end

	// The sound chip waits for data_ready before the next read
	a_no_rd_pending: assert property (@(posedge CLK_48M) disable iff (!rst_n)
		rd_rise |-> sample_req == sample_ack)
		else $error("ADPCM read issued while a sample request is pending");

endmodule

// ==== rtl/neogeo_rom_loader.sv ====
module neogeo_rom_loader import neogeo_loader_pkg::*; (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic                ioctl_wr,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	output logic [PORT1_AW-1:0] port1_addr,
	output logic                port1_we,
	output logic [1:0]          port1_ds,
	output logic [15:0]         port1_d,
	output logic                port1_req,
	input  logic                port1_ack,
	output logic [PORT2_AW-1:0] port2_addr,
	output logic                port2_we,
	output logic [1:0]          port2_ds,
	output logic [15:0]         port2_d,
	output logic                port2_req,
	input  logic                port2_ack,
	input  logic [19:0]         adpcma_addr,
	input  logic [3:0]          adpcma_bank,
	input  logic                adpcma_rd,
	output logic [7:0]          adpcma_data,
	output logic                adpcma_ready,
	output logic [PORT2_AW-1:0] samplea_addr,
	output logic                samplea_req,
	input  logic                samplea_ack,
	input  logic [31:0]         samplea_q,
	input  logic [23:0]         adpcmb_addr,
	input  logic                adpcmb_rd,
	output logic [7:0]          adpcmb_data,
	output logic                adpcmb_ready,
	output logic [PORT2_AW-1:0] sampleb_addr,
	output logic                sampleb_req,
	input  logic                sampleb_ack,
	input  logic [31:0]         sampleb_q
);

	logic                 system_wr;
	logic                 cart_wr;
	logic                 header_wr;
	region_t              region;
	logic [PORT2_AW-1:0]  offset;
	logic [PORT2_AW-1:0]  region_size;
	logic [SIZE_W-1:0]    v1_size;
	logic [SIZE_W-1:0]    c_size;
	logic [SAMPLE_AW-1:0] v1_mask;
	logic [SAMPLE_AW-1:0] v2_mask;
	logic [SAMPLE_AW-1:0] sampleb_mask;
	logic                 pcm_merged;
	logic [PORT2_AW-1:0]  samplea_base;
	logic [PORT2_AW-1:0]  sampleb_base;

	assign port1_we     = system_wr | cart_wr;
	assign port2_we     = cart_wr;
	assign sampleb_mask = pcm_merged ? v1_mask : v2_mask;

	cart_load_ctrl u_ctrl (
		.CLK_48M        (CLK_48M),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.region_size    (region_size),
		.port1_ack      (port1_ack),
		.port2_ack      (port2_ack),
		.system_wr      (system_wr),
		.cart_wr        (cart_wr),
		.header_wr      (header_wr),
		.region         (region),
		.offset         (offset),
		.port1_req      (port1_req),
		.port2_req      (port2_req)
	);

	// Sprite fetch is outside this unit, so c_mask stays open
	cart_header_regs u_header (
		.CLK_48M      (CLK_48M),
		.rst_n        (rst_n),
		.header_wr    (header_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.region       (region),
		.p_size       (),
		.s_size       (),
		.m_size       (),
		.v1_size      (v1_size),
		.v2_size      (),
		.c_size       (c_size),
		.region_size  (region_size),
		.v1_mask      (v1_mask),
		.v2_mask      (v2_mask),
		.c_mask       (),
		.pcm_merged   (pcm_merged),
		.samplea_base (samplea_base),
		.sampleb_base (sampleb_base)
	);

	rom_addr_map u_map (
		.system_wr  (system_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.region     (region),
		.offset     (offset),
		.c_size     (c_size),
		.v1_size    (v1_size),
		.port1_addr (port1_addr),
		.port1_ds   (port1_ds),
		.port2_addr (port2_addr),
		.port2_ds   (port2_ds),
		.port1_d    (port1_d),
		.port2_d    (port2_d)
	);

	adpcm_fetch u_fetch_a (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.rd          (adpcma_rd),
		.addr        ({adpcma_bank, adpcma_addr}),
		.mask        (v1_mask),
		.base        (samplea_base),
		.sample_req  (samplea_req),
		.sample_ack  (samplea_ack),
		.sample_q    (samplea_q),
		.sample_addr (samplea_addr),
		.data        (adpcma_data),
		.data_ready  (adpcma_ready)
	);

	adpcm_fetch u_fetch_b (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.rd          (adpcmb_rd),
		.addr        (adpcmb_addr),
		.mask        (sampleb_mask),
		.base        (sampleb_base),
		.sample_req  (sampleb_req),
		.sample_ack  (sampleb_ack),
		.sample_q    (sampleb_q),
		.sample_addr (sampleb_addr),
		.data        (adpcmb_data),
		.data_ready  (adpcmb_ready)
	);

endmodule

// ==== testbench/tb_neogeo_rom_loader.sv ====
module tb_neogeo_rom_loader import neogeo_loader_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic                CLK_48M;
	logic                rst_n;
	logic                ioctl_download;
	logic [7:0]          ioctl_index;
	logic                ioctl_wr;
	logic [IOCTL_AW-1:0] ioctl_addr;
	logic [7:0]          ioctl_dout;
	logic [PORT1_AW-1:0] port1_addr;
	logic                port1_we;
	logic [1:0]          port1_ds;
	logic [15:0]         port1_d;
	logic                port1_req;
	logic                port1_ack;
	logic [PORT2_AW-1:0] port2_addr;
	logic                port2_we;
	logic [1:0]          port2_ds;
	logic [15:0]         port2_d;
	logic                port2_req;
	logic                port2_ack;
	logic [19:0]         adpcma_addr;
	logic [3:0]          adpcma_bank;
	logic                adpcma_rd;
	logic [7:0]          adpcma_data;
	logic                adpcma_ready;
	logic [PORT2_AW-1:0] samplea_addr;
	logic                samplea_req;
	logic                samplea_ack;
	logic [31:0]         samplea_q;
	logic [23:0]         adpcmb_addr;
	logic                adpcmb_rd;
	logic [7:0]          adpcmb_data;
	logic                adpcmb_ready;
	logic [PORT2_AW-1:0] sampleb_addr;
	logic                sampleb_req;
	logic                sampleb_ack;
	logic [31:0]         sampleb_q;

	logic [15:0]         lfsr = 16'd15;
	int                  value_errors = 0;
	int                  other_errors = 0;
	string               records[$];
	int                  header_count = 0;
	logic                loaded = 1'b0;
	logic [IOCTL_AW-1:0] cart_addr;

	neogeo_rom_loader u_dut (.*);

	initial begin
		CLK_48M = 1'b0;
		forever #5 CLK_48M = ~CLK_48M;
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], b};
		return b;
	endfunction

	function automatic int ack_delay();
		logic [1:0] r;
		r[0] = lfsr_bit();
		r[1] = lfsr_bit();
		return 1 + int'(r);
	endfunction

	function automatic logic [31:0] sample_word(input logic [PORT2_AW-1:0] a);
		logic [31:0] w;
		w = 32'(a & ~26'd3);
		return w * 32'h9E3779B1;
	endfunction

	function automatic logic [7:0] sample_byte(input logic [PORT2_AW-1:0] a);
		logic [31:0] w;
		w = sample_word(a);
		return w[8*a[1:0] +: 8];
	endfunction

	task automatic check_port(input string what, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s toggled port %0d, expected %0d", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_addr(input string what, input logic [PORT2_AW-1:0] got,
			input logic [PORT2_AW-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_lanes(input string what, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic wait_ports_idle(input int gap);
		int n;
		n = 0;
		while ((port1_req !== port1_ack || port2_req !== port2_ack) && n < 50) begin
			@(posedge CLK_48M);
			n++;
		end
		if (n == 50) begin
			$display("Port request at %0t was never acknowledged", $time);
			other_errors++;
		end
		repeat (gap) @(posedge CLK_48M);
	endtask

	// Returns 0 for no toggle, 1 or 2 for a port, 3 for both
	task automatic write_byte(input logic [7:0] idx, input logic [IOCTL_AW-1:0] a,
			input logic [7:0] b, output logic [1:0] toggled);
		logic p1;
		logic p2;
		@(posedge CLK_48M);
		#1;
		ioctl_index = idx;
		ioctl_addr  = a;
		ioctl_dout  = b;
		ioctl_wr    = 1'b1;
		p1 = port1_req;
		p2 = port2_req;
		@(posedge CLK_48M);
		#1;
		ioctl_wr = 1'b0;
		toggled = {port2_req !== p2, port1_req !== p1};
	endtask

	task automatic send_header(input logic [31:0] sizes[6]);
		logic [1:0] t;
		logic [7:0] b;
		for (int a = 0; a < HEADER_BYTES; a++) begin
			b = 8'h00;
			if (a >= SIZE_FIELD_FIRST && a < SIZE_FIELD_END)
				b = sizes[(a - 4) / 4][8*((a - 4) % 4) +: 8];
			write_byte(8'd2, IOCTL_AW'(a), b, t);
			check_port("header byte", t, 2'd0);
			wait_ports_idle(a == HEADER_BYTES - 1 ? 8 : 0);
		end
		cart_addr = IOCTL_AW'(HEADER_BYTES);
	endtask

	task automatic send_system(input logic [7:0] idx, input logic [IOCTL_AW-1:0] a,
			input logic [7:0] b, input logic [PORT2_AW-1:0] exp);
		logic [1:0] t;
		write_byte(idx, a, b, t);
		check_port("system byte", t, 2'd1);
		check_addr("port1 addr", {2'b00, port1_addr}, exp);
		check_lanes("port1 lanes", port1_ds, {exp[0], ~exp[0]});
		check_flag("port1 we", port1_we, 1'b1);
		check_byte("port1 data", port1_d[15:8], b);
		check_byte("port1 data", port1_d[7:0], b);
		wait_ports_idle(8);
	endtask

	task automatic send_cart(input logic [7:0] b, input logic [1:0] port,
			input logic [PORT2_AW-1:0] exp);
		logic [1:0] t;
		write_byte(8'd2, cart_addr, b, t);
		check_port("cart byte", t, port);
		if (port == 2'd1) begin
			check_addr("port1 addr", {2'b00, port1_addr}, exp);
			check_lanes("port1 lanes", port1_ds, {exp[0], ~exp[0]});
			check_flag("port1 we", port1_we, 1'b1);
			check_byte("port1 data", port1_d[15:8], b);
			check_byte("port1 data", port1_d[7:0], b);
		end else begin
			check_addr("port2 addr", port2_addr, exp);
			check_lanes("port2 lanes", port2_ds, {exp[0], ~exp[0]});
			check_flag("port2 we", port2_we, 1'b1);
			check_byte("port2 data", port2_d[15:8], b);
			check_byte("port2 data", port2_d[7:0], b);
		end
		cart_addr++;
		wait_ports_idle(8);
	endtask

	task automatic sample_read(input logic chan_b, input logic [23:0] a,
			input logic [PORT2_AW-1:0] exp, input logic new_req);
		logic r;
		int   n;
		@(posedge CLK_48M);
		#1;
		r = chan_b ? sampleb_req : samplea_req;
		if (chan_b) begin
			adpcmb_addr = a;
			adpcmb_rd   = 1'b1;
		end else begin
			{adpcma_bank, adpcma_addr} = a;
			adpcma_rd = 1'b1;
		end
		@(posedge CLK_48M);
		#1;
		adpcma_rd = 1'b0;
		adpcmb_rd = 1'b0;
		check_flag("sample request toggle", (chan_b ? sampleb_req : samplea_req) !== r,
			new_req);
		check_flag("sample ready", chan_b ? adpcmb_ready : adpcma_ready, !new_req);
		check_addr("sample addr", chan_b ? sampleb_addr : samplea_addr, exp);
		n = 0;
		while (!(chan_b ? adpcmb_ready : adpcma_ready) && n < 50) begin
			@(posedge CLK_48M);
			#1;
			n++;
		end
		if (n == 50) begin
			$display("Sample data at %0t was never ready", $time);
			other_errors++;
		end
		check_byte("sample byte", chan_b ? adpcmb_data : adpcma_data, sample_byte(exp));
		repeat (4) @(posedge CLK_48M);
	endtask

	// SDRAM responders
	initial begin
		forever begin
			@(posedge CLK_48M);
			if (port1_req !== port1_ack) begin
				repeat (ack_delay()) @(posedge CLK_48M);
				#1 port1_ack = port1_req;
			end
		end
	end

	initial begin
		forever begin
			@(posedge CLK_48M);
			if (port2_req !== port2_ack) begin
				repeat (ack_delay()) @(posedge CLK_48M);
				#1 port2_ack = port2_req;
			end
		end
	end

	initial begin
		logic [PORT2_AW-1:0] hold;
		forever begin
			@(posedge CLK_48M);
			if (samplea_req !== samplea_ack) begin
				hold = samplea_addr;
				repeat (ack_delay()) @(posedge CLK_48M);
				#1;
				samplea_q   = sample_word(hold);
				samplea_ack = samplea_req;
			end
		end
	end

	initial begin
		logic [PORT2_AW-1:0] hold;
		forever begin
			@(posedge CLK_48M);
			if (sampleb_req !== sampleb_ack) begin
				hold = sampleb_addr;
				repeat (ack_delay()) @(posedge CLK_48M);
				#1;
				sampleb_q   = sample_word(hold);
				sampleb_ack = sampleb_req;
			end
		end
	end

	initial begin
		longint limit;
		wait (loaded);
		limit = longint'(records.size()) * 100 + longint'(header_count) * 50000;
		repeat (limit) @(posedge CLK_48M);
		$display("Simulation timed out before the trace was finished");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int          fd;
		string       line;
		byte         kind;
		logic [31:0] f[6];
		logic [31:0] sizes[6];
		ioctl_download = 1'b1;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = 8'h00;
		port1_ack      = 1'b0;
		port2_ack      = 1'b0;
		adpcma_addr    = '0;
		adpcma_bank    = '0;
		adpcma_rd      = 1'b0;
		samplea_ack    = 1'b0;
		samplea_q      = '0;
		adpcmb_addr    = '0;
		adpcmb_rd      = 1'b0;
		sampleb_ack    = 1'b0;
		sampleb_q      = '0;
		cart_addr      = IOCTL_AW'(HEADER_BYTES);
		rst_n          = 1'b0;

		fd = $fopen("testbench/loader_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file");
			other_errors++;
		end else begin
			while ($fgets(line, fd)) begin
				if (line.len() > 1 && line[0] != "#") begin
					records.push_back(line);
					if (line[0] == "H")
						header_count++;
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;

		repeat (8) @(posedge CLK_48M);
		#1 rst_n = 1'b1;
		repeat (2) @(posedge CLK_48M);

		foreach (records[i]) begin
			kind = records[i][0];
			case (kind)
				"H": begin
					void'($sscanf(records[i], "%c %h %h %h %h %h %h", kind,
						f[0], f[1], f[2], f[3], f[4], f[5]));
					sizes = f;
					send_header(sizes);
				end
				"S": begin
					void'($sscanf(records[i], "%c %h %h %h %h", kind, f[0], f[1], f[2], f[3]));
					send_system(f[0][7:0], f[1][IOCTL_AW-1:0], f[2][7:0], f[3][PORT2_AW-1:0]);
				end
				"D": begin
					void'($sscanf(records[i], "%c %h %d %h", kind, f[0], f[1], f[2]));
					send_cart(f[0][7:0], f[1][1:0], f[2][PORT2_AW-1:0]);
				end
				"A", "B": begin
					void'($sscanf(records[i], "%c %h %h %d", kind, f[0], f[1], f[2]));
					sample_read(kind == "B", f[0][23:0], f[1][PORT2_AW-1:0], f[2][0]);
				end
				default: begin
					$display("Unknown trace record: %s", records[i]);
					other_errors++;
				end
			endcase
		end

		$display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== testbench/loader_trace.txt ====
# S index addr byte port1_addr | H p s m v1 v2 c sizes
# D byte port addr | A/B sample_addr sdram_addr new_request (hex unless port or flag)
S 00 000010 5a f80010
S 00 080003 a1 de0003
S 00 0a0011 3c e80004
S 01 0c0005 c7 ec0005
H 2 2 2 4 2 4
D 11 1 000000
D 22 1 000001
D 33 1 e00002
D 44 1 e00006
D 55 1 f00000
D 66 1 f00001
D 71 2 000004
D 72 2 000005
D 73 2 000006
D 74 2 000007
D 81 2 000008
D 82 2 000009
D 91 2 00001c
D 92 2 00001e
D 93 2 00001d
D 94 2 00001f
A 000001 000005 1
A 000002 000006 0
A 000007 000007 0
A 100000 000004 0
B 000000 000008 1
B 000003 000009 0
H 0 0 0 8 0 4
D a1 2 000004
D a2 2 000005
D a3 2 000006
D a4 2 000007
D a5 2 000008
D a6 2 000009
D a7 2 00000a
D a8 2 00000b
D b1 2 000014
D b2 2 000016
D b3 2 000015
D b4 2 000017
B 000006 00000a 1
B 00000d 000009 0

// ==== build.f ====
rtl/neogeo_loader_pkg.sv
rtl/cart_load_ctrl.sv
rtl/cart_header_regs.sv
rtl/rom_addr_map.sv
rtl/adpcm_fetch.sv
rtl/neogeo_rom_loader.sv
testbench/tb_neogeo_rom_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_neogeo_rom_loader \
	-f build.f \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
